/* Makefile */
TOP := tb_cce_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

/* logic/cce_dir.sv */
// Coherence directory top level with command stage, per-LCE slices and GAD
`timescale 1ns/1ps

module cce_dir #(
  parameter int num_lce_p   = 4,
  parameter int lce_sets_p  = 16,
  parameter int lce_assoc_p = 4,
  parameter int tag_width_p = 8,
  localparam int lg_num_lce_lp   = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int lg_lce_sets_lp  = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1,
  localparam int lg_lce_assoc_lp = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       cmd_v_i,
  input  cce_dir_pkg::dir_op_e       cmd_op_i,
  input  logic [lg_lce_sets_lp-1:0]  set_i,
  input  logic [lg_num_lce_lp-1:0]   lce_i,
  input  logic [lg_lce_assoc_lp-1:0] way_i,
  input  logic [tag_width_p-1:0]     tag_i,
  input  cce_dir_pkg::coh_state_e    coh_state_i,
  input  logic                       req_write_i,
  input  logic                       lru_dirty_i,
  output logic                       result_v_o,
  output logic [num_lce_p-1:0]       sharers_hits_o,
  output logic [lg_lce_assoc_lp-1:0] req_way_o,
  output logic                       cached_o,
  output logic                       cached_excl_o,
  output logic                       cached_owned_o,
  output logic                       cached_dirty_o,
  output logic                       transfer_o,
  output logic [lg_num_lce_lp-1:0]   transfer_lce_o,
  output logic [lg_lce_assoc_lp-1:0] transfer_way_o,
  output logic                       upgrade_o,
  output logic                       invalidate_o,
  output logic                       replacement_o
);

  import cce_dir_pkg::*;

  // Stage 1 command shared by all slices
  logic [lg_lce_sets_lp-1:0]  set_s1;
  logic [lg_lce_assoc_lp-1:0] way_s1;
  logic [tag_width_p-1:0]     tag_s1;
  coh_state_e                 state_s1;
  logic [num_lce_p-1:0]       wr_en_s1;
  logic                       clr_s1;
  logic                       lookup_s1;

  // Stage 2 request fields for the GAD
  logic                       lookup_s2;
  logic [lg_num_lce_lp-1:0]   req_lce_s2;
  logic                       req_write_s2;
  logic                       lru_dirty_s2;

  // Slice results
  logic [num_lce_p-1:0]                      slice_hits;
  logic [num_lce_p-1:0][lg_lce_assoc_lp-1:0] slice_ways;
  coh_state_e [num_lce_p-1:0]                slice_states;

  dir_cmd_stage #(
    .num_lce_p  (num_lce_p),
    .lce_sets_p (lce_sets_p),
    .lce_assoc_p(lce_assoc_p),
    .tag_width_p(tag_width_p)
  ) i_dir_cmd_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_op_i   (cmd_op_i),
    .set_i      (set_i),
    .lce_i      (lce_i),
    .way_i      (way_i),
    .tag_i      (tag_i),
    .coh_state_i(coh_state_i),
    .req_write_i(req_write_i),
    .lru_dirty_i(lru_dirty_i),
    .set_o      (set_s1),
    .way_o      (way_s1),
    .tag_o      (tag_s1),
    .coh_state_o(state_s1),
    .wr_en_o    (wr_en_s1),
    .clr_o      (clr_s1),
    .lookup_o   (lookup_s1),
    .lookup_d_o (lookup_s2),
    .req_lce_o  (req_lce_s2),
    .req_write_o(req_write_s2),
    .lru_dirty_o(lru_dirty_s2)
  );

  // One slice per LCE
  for (genvar g = 0; g < num_lce_p; g++) begin : g_slice
    dir_lce_slice #(
      .lce_sets_p (lce_sets_p),
      .lce_assoc_p(lce_assoc_p),
      .tag_width_p(tag_width_p)
    ) i_dir_lce_slice (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .set_i      (set_s1),
      .way_i      (way_s1),
      .tag_i      (tag_s1),
      .coh_state_i(state_s1),
      .wr_en_i    (wr_en_s1[g]),
      .clr_i      (clr_s1),
      .lookup_i   (lookup_s1),
      .hit_o      (slice_hits[g]),
      .hit_way_o  (slice_ways[g]),
      .hit_state_o(slice_states[g])
    );
  end

  dir_gad #(
    .num_lce_p  (num_lce_p),
    .lce_assoc_p(lce_assoc_p)
  ) i_dir_gad (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .lookup_i        (lookup_s2),
    .sharers_hits_i  (slice_hits),
    .sharers_ways_i  (slice_ways),
    .sharers_states_i(slice_states),
    .req_lce_i       (req_lce_s2),
    .req_write_i     (req_write_s2),
    .lru_dirty_i     (lru_dirty_s2),
    .result_v_o      (result_v_o),
    .sharers_hits_o  (sharers_hits_o),
    .req_way_o       (req_way_o),
    .cached_o        (cached_o),
    .cached_excl_o   (cached_excl_o),
    .cached_owned_o  (cached_owned_o),
    .cached_dirty_o  (cached_dirty_o),
    .transfer_o      (transfer_o),
    .transfer_lce_o  (transfer_lce_o),
    .transfer_way_o  (transfer_way_o),
    .upgrade_o       (upgrade_o),
    .invalidate_o    (invalidate_o),
    .replacement_o   (replacement_o)
  );

endmodule

/* logic/cce_dir_pkg.sv */
// Coherence state type, directory command opcodes and state width
package cce_dir_pkg;

  //////////////////////////////////////////////////////////////////////
  // Coherence states
  //////////////////////////////////////////////////////////////////////

  // State of one directory entry
  // Invalid is zero so a cleared entry reads as a miss
  typedef enum logic [2:0] {
    // Not present in the LCE
    e_coh_i = 3'd0,
    // Clean copy, possibly shared with other LCEs
    e_coh_s = 3'd1,
    // Clean and exclusive
    e_coh_e = 3'd2,
    // Dirty and exclusive
    e_coh_m = 3'd3,
    // Dirty and shared, this LCE supplies data
    e_coh_o = 3'd4
  } coh_state_e;

  // Bits needed to hold one state in the directory arrays
  localparam int coh_bits_c = $bits(coh_state_e);

  //////////////////////////////////////////////////////////////////////
  // Directory commands
  //////////////////////////////////////////////////////////////////////

  // Opcode sampled with the command strobe
  typedef enum logic [1:0] {
    // Look up one set in every LCE and run the GAD
    e_dir_rd_set   = 2'd0,
    // Write tag and state of one way in one LCE
    e_dir_wr_entry = 2'd1,
    // Invalidate every way of one set in all LCEs
    e_dir_clr_set  = 2'd2,
    // No operation
    e_dir_nop      = 2'd3
  } dir_op_e;

endpackage

/* logic/dir_cmd_stage.sv */
// Directory command stage with opcode decode, stage 1 registers and stage 2 request fields
`timescale 1ns/1ps

module dir_cmd_stage #(
  parameter int num_lce_p   = 4,
  parameter int lce_sets_p  = 16,
  parameter int lce_assoc_p = 4,
  parameter int tag_width_p = 8,
  localparam int lg_num_lce_lp   = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int lg_lce_sets_lp  = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1,
  localparam int lg_lce_assoc_lp = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cmd_v_i,
  input  cce_dir_pkg::dir_op_e      cmd_op_i,
  input  logic [lg_lce_sets_lp-1:0] set_i,
  input  logic [lg_num_lce_lp-1:0]  lce_i,
  input  logic [lg_lce_assoc_lp-1:0] way_i,
  input  logic [tag_width_p-1:0]    tag_i,
  input  cce_dir_pkg::coh_state_e   coh_state_i,
  input  logic                      req_write_i,
  input  logic                      lru_dirty_i,
  output logic [lg_lce_sets_lp-1:0] set_o,
  output logic [lg_lce_assoc_lp-1:0] way_o,
  output logic [tag_width_p-1:0]    tag_o,
  output cce_dir_pkg::coh_state_e   coh_state_o,
  output logic [num_lce_p-1:0]      wr_en_o,
  output logic                      clr_o,
  output logic                      lookup_o,
  output logic                      lookup_d_o,
  output logic [lg_num_lce_lp-1:0]  req_lce_o,
  output logic                      req_write_o,
  output logic                      lru_dirty_o
);

  import cce_dir_pkg::*;

  // Decoded strobes for stage 1
  logic [num_lce_p-1:0]     wr_en_n;
  logic                     clr_n;
  logic                     lookup_n;

  // Requester fields riding along with stage 1
  logic [lg_num_lce_lp-1:0] req_lce_q;
  logic                     req_write_q;
  logic                     lru_dirty_q;

  // Opcode decode, only for a valid command
  always_comb begin
    wr_en_n  = '0;
    clr_n    = 1'b0;
    lookup_n = 1'b0;
    if (cmd_v_i) begin
      case (cmd_op_i)
        e_dir_rd_set:   lookup_n = 1'b1;
        e_dir_wr_entry: wr_en_n[lce_i] = 1'b1;
        e_dir_clr_set:  clr_n = 1'b1;
        e_dir_nop:      ;
        default:        ;
      endcase
    end
  end

  // Strobes for both stages
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_en_o    <= '0;
      clr_o      <= 1'b0;
      lookup_o   <= 1'b0;
      lookup_d_o <= 1'b0;
    end else begin
      wr_en_o    <= wr_en_n;
      clr_o      <= clr_n;
      lookup_o   <= lookup_n;
      lookup_d_o <= lookup_o;
    end
  end

  // Stage 1 command fields
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      set_o       <= set_i;
      way_o       <= way_i;
      tag_o       <= tag_i;
      coh_state_o <= coh_state_i;
      req_lce_q   <= lce_i;
      req_write_q <= req_write_i;
      lru_dirty_q <= lru_dirty_i;
    end
  end

  // Stage 2 copies line up with the slice results
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      req_lce_o   <= req_lce_q;
      req_write_o <= req_write_q;
      lru_dirty_o <= lru_dirty_q;
    end
  end

endmodule

/* logic/dir_gad.sv */
// Auxiliary directory logic that turns slice results into coherence flags and a transfer choice
`timescale 1ns/1ps

module dir_gad #(
  parameter int num_lce_p   = 4,
  parameter int lce_assoc_p = 4,
  localparam int lg_num_lce_lp   = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int lg_lce_assoc_lp = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      lookup_i,
  input  logic [num_lce_p-1:0]                      sharers_hits_i,
  input  logic [num_lce_p-1:0][lg_lce_assoc_lp-1:0] sharers_ways_i,
  input  cce_dir_pkg::coh_state_e [num_lce_p-1:0]   sharers_states_i,
  input  logic [lg_num_lce_lp-1:0]                  req_lce_i,
  input  logic                                      req_write_i,
  input  logic                                      lru_dirty_i,
  output logic                                      result_v_o,
  output logic [num_lce_p-1:0]                      sharers_hits_o,
  output logic [lg_lce_assoc_lp-1:0]                req_way_o,
  output logic                                      cached_o,
  output logic                                      cached_excl_o,
  output logic                                      cached_owned_o,
  output logic                                      cached_dirty_o,
  output logic                                      transfer_o,
  output logic [lg_num_lce_lp-1:0]                  transfer_lce_o,
  output logic [lg_lce_assoc_lp-1:0]                transfer_way_o,
  output logic                                      upgrade_o,
  output logic                                      invalidate_o,
  output logic                                      replacement_o
);

  import cce_dir_pkg::*;

  // Requester view
  logic       req_hit;
  coh_state_e req_state;

  // Flags before the output register
  logic                       cached_n;
  logic                       excl_n;
  logic                       owned_n;
  logic                       dirty_n;
  logic                       transfer_n;
  logic                       upgrade_n;
  logic                       invalidate_n;
  logic                       replacement_n;
  logic [lg_num_lce_lp-1:0]   tr_lce_n;
  logic [lg_lce_assoc_lp-1:0] tr_way_n;

  //////////////////////////////////////////////////////////////////////
  // Flags from the other LCEs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cached_n = 1'b0;
    excl_n   = 1'b0;
    owned_n  = 1'b0;
    dirty_n  = 1'b0;
    tr_lce_n = '0;
    tr_way_n = '0;
    // Downward scan leaves the lowest owner as transfer source
    for (int i = num_lce_p - 1; i >= 0; i--) begin
      if (sharers_hits_i[i] && (i != int'(req_lce_i))) begin
        cached_n = 1'b1;
        if (sharers_states_i[i] == e_coh_e) begin
          excl_n = 1'b1;
        end
        if (sharers_states_i[i] inside {e_coh_e, e_coh_m, e_coh_o}) begin
          owned_n  = 1'b1;
          tr_lce_n = lg_num_lce_lp'(i);
          tr_way_n = sharers_ways_i[i];
        end
        if (sharers_states_i[i] inside {e_coh_m, e_coh_o}) begin
          dirty_n = 1'b1;
        end
      end
    end
  end

  assign req_hit   = sharers_hits_i[req_lce_i];
  assign req_state = sharers_states_i[req_lce_i];

  // Owner supplies data only when the requester lacks the line
  assign transfer_n    = owned_n & ~req_hit;
  assign upgrade_n     = req_hit & (req_state == e_coh_s) & req_write_i;
  assign invalidate_n  = req_write_i & cached_n;
  assign replacement_n = lru_dirty_i & ~upgrade_n;

  // Results hold until the next lookup
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_v_o     <= 1'b0;
      sharers_hits_o <= '0;
      req_way_o      <= '0;
      cached_o       <= 1'b0;
      cached_excl_o  <= 1'b0;
      cached_owned_o <= 1'b0;
      cached_dirty_o <= 1'b0;
      transfer_o     <= 1'b0;
      transfer_lce_o <= '0;
      transfer_way_o <= '0;
      upgrade_o      <= 1'b0;
      invalidate_o   <= 1'b0;
      replacement_o  <= 1'b0;
    end else begin
      result_v_o <= lookup_i;
      if (lookup_i) begin
        sharers_hits_o <= sharers_hits_i;
        req_way_o      <= sharers_ways_i[req_lce_i];
        cached_o       <= cached_n;
        cached_excl_o  <= excl_n;
        cached_owned_o <= owned_n;
        cached_dirty_o <= dirty_n;
        transfer_o     <= transfer_n;
        transfer_lce_o <= tr_lce_n;
        transfer_way_o <= tr_way_n;
        upgrade_o      <= upgrade_n;
        invalidate_o   <= invalidate_n;
        replacement_o  <= replacement_n;
      end
    end
  end

endmodule

/* logic/dir_lce_slice.sv */
// Per-LCE directory slice with tag and state arrays, entry write, set clear and tag lookup
`timescale 1ns/1ps

module dir_lce_slice #(
  parameter int lce_sets_p  = 16,
  parameter int lce_assoc_p = 4,
  parameter int tag_width_p = 8,
  localparam int lg_lce_sets_lp  = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1,
  localparam int lg_lce_assoc_lp = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [lg_lce_sets_lp-1:0]  set_i,
  input  logic [lg_lce_assoc_lp-1:0] way_i,
  input  logic [tag_width_p-1:0]     tag_i,
  input  cce_dir_pkg::coh_state_e    coh_state_i,
  input  logic                       wr_en_i,
  input  logic                       clr_i,
  input  logic                       lookup_i,
  output logic                       hit_o,
  output logic [lg_lce_assoc_lp-1:0] hit_way_o,
  output cce_dir_pkg::coh_state_e    hit_state_o
);

  import cce_dir_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  logic [tag_width_p-1:0] tag_mem   [lce_sets_p][lce_assoc_p];
  logic [coh_bits_c-1:0]  state_mem [lce_sets_p][lce_assoc_p];

  // Lookup result before the output register
  logic                       hit_n;
  logic [lg_lce_assoc_lp-1:0] hit_way_n;
  logic [coh_bits_c-1:0]      hit_state_n;

  // Tags only change on an entry write
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[set_i][way_i] <= tag_i;
    end
  end

  // States start invalid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < lce_sets_p; s++) begin
        for (int w = 0; w < lce_assoc_p; w++) begin
          state_mem[s][w] <= e_coh_i;
        end
      end
    end else if (wr_en_i) begin
      state_mem[set_i][way_i] <= coh_state_i;
    end else if (clr_i) begin
      // Whole set goes invalid
      for (int w = 0; w < lce_assoc_p; w++) begin
        state_mem[set_i][w] <= e_coh_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag lookup
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_n       = 1'b0;
    hit_way_n   = '0;
    hit_state_n = e_coh_i;
    // Scan downward so the lowest matching way is kept
    for (int w = lce_assoc_p - 1; w >= 0; w--) begin
      if ((state_mem[set_i][w] != e_coh_i) && (tag_mem[set_i][w] == tag_i)) begin
        hit_n       = 1'b1;
        hit_way_n   = lg_lce_assoc_lp'(w);
        hit_state_n = state_mem[set_i][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hit_o <= 1'b0;
    end else if (lookup_i) begin
      hit_o <= hit_n;
    end
  end

  // Way and state of the hit, zero and invalid on a miss
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      hit_way_o   <= hit_way_n;
      hit_state_o <= coh_state_e'(hit_state_n);
    end
  end

endmodule

/* test/cce_dir_patterns.txt */
# name op set lce way tag state rw lru_dirty | hits req_way cached excl owned dirty xfer xfer_lce xfer_way upgrade inval repl
# op 0 read 1 write 2 clear 3 nop, state 0 I 1 S 2 E 3 M 4 O, set tag hits in hex
rst_a       0 0 0 0 00 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
rst_b       0 f 3 0 a5 0 1 0   0 0 0 0 0 0 0 0 0 0 0 0
rst_c       0 7 2 0 3c 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_l0       1 3 0 1 42 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_l2       1 3 2 3 42 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_l1       1 3 1 0 17 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
hit_l0      0 3 0 0 42 0 0 0   5 1 1 0 0 0 0 0 0 0 0 0
hit_l1miss  0 3 1 0 42 0 0 0   5 0 1 0 0 0 0 0 0 0 0 0
tag17       0 3 1 0 17 0 0 0   2 0 0 0 0 0 0 0 0 0 0 0
other_set   0 4 0 0 42 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
other_tag   0 3 3 0 43 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_e1       1 5 1 2 80 2 0 0   0 0 0 0 0 0 0 0 0 0 0 0
own_e       0 5 0 0 80 0 0 0   2 0 1 1 1 0 1 1 2 0 0 0
wr_m3       1 5 3 1 80 3 0 0   0 0 0 0 0 0 0 0 0 0 0 0
own_em      0 5 0 0 80 0 0 0   a 0 1 1 1 1 1 1 2 0 0 0
wr_s1       1 5 1 2 80 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
own_m       0 5 0 0 80 0 0 0   a 0 1 0 1 1 1 3 1 0 0 0
wr_o3       1 5 3 1 80 4 0 0   0 0 0 0 0 0 0 0 0 0 0 0
own_o_wr    0 5 2 0 80 0 1 0   a 0 1 0 1 1 1 3 1 0 1 0
req_owner   0 5 3 0 80 0 0 0   a 1 1 0 0 0 0 0 0 0 0 0
req_shared  0 5 1 0 80 0 0 0   a 2 1 0 1 1 0 3 1 0 0 0
wr_s0       1 9 0 3 21 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
upg_alone   0 9 0 0 21 0 1 0   1 3 0 0 0 0 0 0 0 1 0 0
wr_s2       1 9 2 0 21 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
upg_inv     0 9 0 0 21 0 1 1   5 3 1 0 0 0 0 0 0 1 1 0
repl_rd     0 9 0 0 21 0 0 1   5 3 1 0 0 0 0 0 0 0 0 1
miss_wr     0 9 1 0 21 0 1 1   5 0 1 0 0 0 0 0 0 0 1 1
clr_5       2 5 0 0 00 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
clr5_rd_a   0 5 0 0 80 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
clr5_rd_b   0 5 3 0 80 0 1 0   0 0 0 0 0 0 0 0 0 0 0 0
clr_3       2 3 2 0 00 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
clr3_rd     0 3 0 0 42 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
clr3_rd17   0 3 1 0 17 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
keep_9      0 9 2 0 21 0 0 0   5 0 1 0 0 0 0 0 0 0 0 0
wr_m2       1 c 2 1 ee 3 0 0   0 0 0 0 0 0 0 0 0 0 0 0
raw_m       0 c 0 0 ee 0 0 0   4 0 1 0 1 1 1 2 1 0 0 0
wr_s2c      1 c 2 1 ee 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
raw_s       0 c 0 0 ee 0 1 0   4 0 1 0 0 0 0 0 0 0 1 0
raw_upg     0 c 2 0 ee 0 1 0   4 1 0 0 0 0 0 0 0 1 0 0
wr_e0       1 c 0 2 ee 2 0 0   0 0 0 0 0 0 0 0 0 0 0 0
raw_e_req   0 c 2 0 ee 0 0 0   5 1 1 1 1 0 0 0 2 0 0 0
raw_e_oth   0 c 1 0 ee 0 0 0   5 0 1 1 1 0 1 0 2 0 0 0
nop         3 c 0 2 ee 4 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_tag11    1 c 0 2 11 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
retag       0 c 1 0 ee 0 0 0   4 0 1 0 0 0 0 0 0 0 0 0
wr_s3w3     1 c 3 3 ee 1 0 0   0 0 0 0 0 0 0 0 0 0 0 0
wr_e3w1     1 c 3 1 ee 2 0 0   0 0 0 0 0 0 0 0 0 0 0 0
low_way     0 c 3 0 ee 0 0 0   c 1 1 0 0 0 0 0 0 0 0 0

/* test/cce_dir_sva.sv */
// Bound assertions on directory read timing, result pulse and coherence flag consistency
`timescale 1ns/1ps

module cce_dir_sva (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 cmd_v_i,
  input cce_dir_pkg::dir_op_e cmd_op_i,
  input logic                 result_v_o,
  input logic                 transfer_o,
  input logic                 cached_owned_o,
  input logic                 cached_dirty_o
);

  import cce_dir_pkg::*;

  logic rd_sampled;

  assign rd_sampled = cmd_v_i && (cmd_op_i == e_dir_rd_set);

  // Result is registered after edge k+2, so it is seen at edge k+3
  a_rd_gives_result : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) rd_sampled |-> ##3 result_v_o
  ) else $error("read command produced no result pulse");

  a_result_has_rd : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) result_v_o |-> $past(rd_sampled, 3)
  ) else $error("result pulse without a matching read command");

  a_transfer_owned : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) transfer_o |-> cached_owned_o
  ) else $error("transfer flagged without an owner");

  a_dirty_owned : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) cached_dirty_o |-> cached_owned_o
  ) else $error("dirty flagged without an owner");

  a_reset_quiet : assert property (
    @(posedge clk_i) !arst_n_i |-> !result_v_o
  ) else $error("result pulse during reset");

endmodule

bind cce_dir cce_dir_sva i_cce_dir_sva (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .cmd_v_i       (cmd_v_i),
  .cmd_op_i      (cmd_op_i),
  .result_v_o    (result_v_o),
  .transfer_o    (transfer_o),
  .cached_owned_o(cached_owned_o),
  .cached_dirty_o(cached_dirty_o)
);

/* test/tb_cce_dir.sv */
// Testbench for the coherence directory, driven from a pattern file with in-order result checks
`timescale 1ns/1ps

module tb_cce_dir;

  import cce_dir_pkg::*;

  localparam int num_lce_lp       = 4;
  localparam int lce_sets_lp      = 16;
  localparam int lce_assoc_lp     = 4;
  localparam int tag_width_lp     = 8;
  localparam int lg_num_lce_lp    = $clog2(num_lce_lp);
  localparam int lg_lce_sets_lp   = $clog2(lce_sets_lp);
  localparam int lg_lce_assoc_lp  = $clog2(lce_assoc_lp);
  localparam logic [31:0] seed_lp = 32'hfdfd876a;
  localparam int drain_timeout_lp = 50;
  localparam string pattern_file_lp = "test/cce_dir_patterns.txt";

  // One outstanding read and the results it should produce
  typedef struct {
    string name;
    int    hits;
    int    req_way;
    int    cached;
    int    excl;
    int    owned;
    int    dirty;
    int    transfer;
    int    tr_lce;
    int    tr_way;
    int    upgrade;
    int    inval;
    int    repl;
  } expect_t;

  logic                       clk_i = 1'b0;
  logic                       arst_n_i;
  logic                       cmd_v_i;
  dir_op_e                    cmd_op_i;
  logic [lg_lce_sets_lp-1:0]  set_i;
  logic [lg_num_lce_lp-1:0]   lce_i;
  logic [lg_lce_assoc_lp-1:0] way_i;
  logic [tag_width_lp-1:0]    tag_i;
  coh_state_e                 coh_state_i;
  logic                       req_write_i;
  logic                       lru_dirty_i;
  logic                       result_v_o;
  logic [num_lce_lp-1:0]      sharers_hits_o;
  logic [lg_lce_assoc_lp-1:0] req_way_o;
  logic                       cached_o;
  logic                       cached_excl_o;
  logic                       cached_owned_o;
  logic                       cached_dirty_o;
  logic                       transfer_o;
  logic [lg_num_lce_lp-1:0]   transfer_lce_o;
  logic [lg_lce_assoc_lp-1:0] transfer_way_o;
  logic                       upgrade_o;
  logic                       invalidate_o;
  logic                       replacement_o;

  expect_t expect_q[$];
  int      results_seen;

  cce_dir #(
    .num_lce_p  (num_lce_lp),
    .lce_sets_p (lce_sets_lp),
    .lce_assoc_p(lce_assoc_lp),
    .tag_width_p(tag_width_lp)
  ) i_cce_dir (
    .clk_i, .arst_n_i, .cmd_v_i, .cmd_op_i, .set_i, .lce_i, .way_i, .tag_i,
    .coh_state_i, .req_write_i, .lru_dirty_i, .result_v_o, .sharers_hits_o,
    .req_way_o, .cached_o, .cached_excl_o, .cached_owned_o, .cached_dirty_o,
    .transfer_o, .transfer_lce_o, .transfer_way_o, .upgrade_o, .invalidate_o,
    .replacement_o
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_and_stop();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string test, input string field, input int expected,
                             input logic [31:0] actual);
    if (32'(expected) !== actual) begin
      $display("Error %s %s expected %0h actual %0h", test, field, expected, actual);
      fail_and_stop();
    end
  endtask

  // One command held for one cycle and sampled at the next rising edge
  task automatic issue_command(input int op, input int set_idx, input int lce, input int way,
                               input int tag, input int state, input int rw, input int ld);
    cmd_v_i     = 1'b1;
    cmd_op_i    = dir_op_e'(op[1:0]);
    set_i       = lg_lce_sets_lp'(set_idx);
    lce_i       = lg_num_lce_lp'(lce);
    way_i       = lg_lce_assoc_lp'(way);
    tag_i       = tag_width_lp'(tag);
    coh_state_i = coh_state_e'(state[2:0]);
    req_write_i = rw[0];
    lru_dirty_i = ld[0];
    @(negedge clk_i);
    cmd_v_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result checker
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : result_monitor
    expect_t e;
    if (arst_n_i && result_v_o) begin
      if (expect_q.size() == 0) begin
        $display("A result arrived while no read was outstanding");
        fail_and_stop();
      end else begin
        e = expect_q.pop_front();
        check_value(e.name, "hits", e.hits, 32'(sharers_hits_o));
        check_value(e.name, "req_way", e.req_way, 32'(req_way_o));
        check_value(e.name, "cached", e.cached, 32'(cached_o));
        check_value(e.name, "cached_excl", e.excl, 32'(cached_excl_o));
        check_value(e.name, "cached_owned", e.owned, 32'(cached_owned_o));
        check_value(e.name, "cached_dirty", e.dirty, 32'(cached_dirty_o));
        check_value(e.name, "transfer", e.transfer, 32'(transfer_o));
        check_value(e.name, "transfer_lce", e.tr_lce, 32'(transfer_lce_o));
        check_value(e.name, "transfer_way", e.tr_way, 32'(transfer_way_o));
        check_value(e.name, "upgrade", e.upgrade, 32'(upgrade_o));
        check_value(e.name, "invalidate", e.inval, 32'(invalidate_o));
        check_value(e.name, "replacement", e.repl, 32'(replacement_o));
        results_seen++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int          fd;
    int          n;
    int          op;
    int          set_idx;
    int          lce;
    int          way;
    int          tag;
    int          state;
    int          rw;
    int          ld;
    int          idle;
    int          wait_cycles;
    string       line;
    logic [31:0] rnd;
    expect_t     e;

    results_seen = 0;
    arst_n_i     = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_op_i     = e_dir_nop;
    set_i        = '0;
    lce_i        = '0;
    way_i        = '0;
    tag_i        = '0;
    coh_state_i  = e_coh_i;
    req_write_i  = 1'b0;
    lru_dirty_i  = 1'b0;
    rnd          = seed_lp;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    fd = $fopen(pattern_file_lp, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", pattern_file_lp);
      fail_and_stop();
    end
    @(negedge clk_i);

    while ($fgets(line, fd) != 0) begin
      // Skip comments and empty lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %d %h %d %d %h %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d",
                  e.name, op, set_idx, lce, way, tag, state, rw, ld, e.hits, e.req_way,
                  e.cached, e.excl, e.owned, e.dirty, e.transfer, e.tr_lce, e.tr_way,
                  e.upgrade, e.inval, e.repl);
      if (n != 21) begin
        $display("Pattern line could not be parsed: %s", line);
        fail_and_stop();
      end
      if (op == 0) begin
        expect_q.push_back(e);
      end
      issue_command(op, set_idx, lce, way, tag, state, rw, ld);
      // Random gap of 0 to 2 idle cycles
      rnd  = lcg_next(rnd);
      idle = int'((rnd >> 16) % 32'd3);
      repeat (idle) @(negedge clk_i);
    end
    $fclose(fd);

    // Drain outstanding reads
    wait_cycles = 0;
    while (expect_q.size() != 0 && wait_cycles < drain_timeout_lp) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    if (expect_q.size() != 0) begin
      $display("A read result never arrived, %0d reads still outstanding", expect_q.size());
      fail_and_stop();
    end else begin
      $display("%0d read results checked", results_seen);
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* vlog.f */
logic/cce_dir_pkg.sv
logic/dir_cmd_stage.sv
logic/dir_lce_slice.sv
logic/dir_gad.sv
logic/cce_dir.sv
test/cce_dir_sva.sv
test/tb_cce_dir.sv
